// File: hdl/rv32_branch_pkg.sv
package rv32_branch_pkg;

    // Branch behaviour carried down the pipe with each instruction
    typedef enum logic [1:0] {
        // Not a branch
        BRANCH_NEVER    = 2'b00,
        // Taken when the ALU result is zero
        BRANCH_ZERO     = 2'b01,
        // Taken when the ALU result is non-zero
        BRANCH_NON_ZERO = 2'b10,
        // Jumps
        BRANCH_ALWAYS   = 2'b11
    } branch_op_t;

endpackage

// File: hdl/rv32_mem_pkg.sv
package rv32_mem_pkg;

    // Data and address width
    localparam int XLEN = 32;

    // Register index width
    localparam int REG_ADDR_BITS = 5;

    // Word index width of the data RAM, 256 words
    localparam int RAM_ADDR_BITS = 8;

    // Load and store access width, code 2'b11 is unused
    typedef enum logic [1:0] {
        WIDTH_WORD = 2'b00,
        WIDTH_HALF = 2'b01,
        WIDTH_BYTE = 2'b10
    } mem_width_t;

endpackage

// File: hdl/rv32_branch_unit.sv
module rv32_branch_unit (
    input  logic                        predicted_taken,
    input  logic                        alu_non_zero,
    input  rv32_branch_pkg::branch_op_t op,
    output logic                        mispredicted
);
    import rv32_branch_pkg::*;

    logic taken;

    // Actual outcome of the branch
    always_comb begin
        case (op)
            BRANCH_NEVER:    taken = 1'b0;
            BRANCH_ZERO:     taken = ~alu_non_zero;
            BRANCH_NON_ZERO: taken = alu_non_zero;
            BRANCH_ALWAYS:   taken = 1'b1;
            default:         taken = 1'b0;
        endcase
    end

    // Fetch guessed wrong, the front end has to redirect
    assign mispredicted = taken ^ predicted_taken;

endmodule

// File: hdl/rv32_mem.sv
module rv32_mem (
    input  logic                        clk,
    input  logic                        reset_,

    // From the hazard unit
    input  logic                        stall,
    input  logic                        flush,

    // Control from execute
    input  logic                        branch_predicted_taken,
    input  logic                        valid,
    input  logic                        alu_non_zero,
    input  logic                        read,
    input  logic                        write,
    input  rv32_mem_pkg::mem_width_t    width,
    input  logic                        zero_extend,
    input  rv32_branch_pkg::branch_op_t branch_op,
    input  logic [4:0]                  rd,
    input  logic                        rd_write,

    // Data from execute
    input  logic [31:0]                 result,
    input  logic [31:0]                 rs2_value,
    input  logic [31:0]                 branch_pc,

    // Data RAM read data
    input  logic [31:0]                 data_read_value,

    // Writeback register
    output logic                        valid_out,
    output logic                        branch_mispredicted,
    output logic [4:0]                  rd_out,
    output logic                        rd_write_out,

    // Data RAM bus
    output logic                        data_read,
    output logic                        data_write,
    output logic [3:0]                  data_write_mask,

    output logic [31:0]                 rd_value_out,
    output logic [31:0]                 branch_pc_out,

    output logic [31:0]                 data_address,
    output logic [31:0]                 data_write_value
);
    import rv32_mem_pkg::*;

    logic [15:0]     load_half;
    logic [7:0]      load_byte;
    logic [XLEN-1:0] load_value;

    // ####################################################################
    // Branch resolution

    rv32_branch_unit branch_unit0 (
        .predicted_taken (branch_predicted_taken),
        .alu_non_zero    (alu_non_zero),
        .op              (branch_op),
        .mispredicted    (branch_mispredicted)
    );

    assign branch_pc_out = branch_pc;

    // ####################################################################
    // Store lane steering

    assign data_read    = read;
    assign data_write   = write;
    assign data_address = result;

    always_comb begin
        data_write_value = rs2_value;
        data_write_mask  = 4'b0000;
        if (write) begin
            case (width)
                WIDTH_WORD: begin
                    data_write_mask = 4'b1111;
                end
                WIDTH_HALF: begin
                    // Same halfword on both lanes so the mask can pick one
                    data_write_value = {2{rs2_value[15:0]}};
                    data_write_mask  = result[1] ? 4'b1100 : 4'b0011;
                end
                WIDTH_BYTE: begin
                    data_write_value = {4{rs2_value[7:0]}};
                    data_write_mask  = 4'b0001 << result[1:0];
                end
                default: begin
                    data_write_mask = 4'b0000;
                end
            endcase
        end
    end

    // ####################################################################
    // Load lane select and extension

    assign load_half = result[1] ? data_read_value[31:16] : data_read_value[15:0];

    always_comb begin
        case (result[1:0])
            2'b00:   load_byte = data_read_value[7:0];
            2'b01:   load_byte = data_read_value[15:8];
            2'b10:   load_byte = data_read_value[23:16];
            default: load_byte = data_read_value[31:24];
        endcase
    end

    always_comb begin
        case (width)
            WIDTH_HALF: begin
                load_value = {{16{load_half[15] & ~zero_extend}}, load_half};
            end
            WIDTH_BYTE: begin
                load_value = {{24{load_byte[7] & ~zero_extend}}, load_byte};
            end
            default: begin
                load_value = data_read_value;
            end
        endcase
    end

    // ####################################################################
    // Writeback pipeline register

    always_ff @(posedge clk) begin
        if (!reset_) begin
            valid_out    <= 1'b0;
            rd_out       <= '0;
            rd_write_out <= 1'b0;
            rd_value_out <= '0;
        end else if (!stall) begin
            // A flushed slot still loads its fields but writes nothing
            valid_out    <= valid & ~flush;
            rd_write_out <= rd_write & ~flush;
            rd_out       <= rd;
            rd_value_out <= read ? load_value : result;
        end
    end

endmodule

// File: hdl/rv32_data_ram.sv
module rv32_data_ram (
    input  logic                          clk,
    input  logic                          write,
    input  logic [3:0]                    write_mask,
    input  logic [rv32_mem_pkg::XLEN-1:0] address,
    input  logic [rv32_mem_pkg::XLEN-1:0] write_value,
    output logic [rv32_mem_pkg::XLEN-1:0] read_value
);
    import rv32_mem_pkg::*;

    localparam int DEPTH = 1 << RAM_ADDR_BITS;

    logic [XLEN-1:0]          mem [DEPTH];
    logic [RAM_ADDR_BITS-1:0] word_index;

    // Upper address bits alias onto the same 256 words
    assign word_index = address[RAM_ADDR_BITS+1:2];

    always_ff @(posedge clk) begin
        if (write) begin
            for (int lane = 0; lane < 4; lane++) begin
                if (write_mask[lane]) begin
                    mem[word_index][lane*8 +: 8] <= write_value[lane*8 +: 8];
                end
            end
        end
    end

    assign read_value = mem[word_index];

endmodule

// File: hdl/rv32_regfile.sv
module rv32_regfile (
    input  logic                                   clk,
    input  logic                                   write,
    input  logic [rv32_mem_pkg::REG_ADDR_BITS-1:0] write_addr,
    input  logic [rv32_mem_pkg::XLEN-1:0]          write_value,
    input  logic [rv32_mem_pkg::REG_ADDR_BITS-1:0] read_addr,
    output logic [rv32_mem_pkg::XLEN-1:0]          read_value
);
    import rv32_mem_pkg::*;

    localparam int NUM_REGS = 1 << REG_ADDR_BITS;

    logic [XLEN-1:0] regs [NUM_REGS];

    // x0 is never written
    always_ff @(posedge clk) begin
        if (write && write_addr != '0) begin
            regs[write_addr] <= write_value;
        end
    end

    assign read_value = (read_addr == '0) ? '0 : regs[read_addr];

endmodule

// File: hdl/rv32_mem_top.sv
module rv32_mem_top (
    input  logic                        clk,
    input  logic                        reset_,

    // Hazard control
    input  logic                        stall,
    input  logic                        flush,

    // Stage inputs from execute
    input  logic                        valid,
    input  logic                        branch_predicted_taken,
    input  logic                        alu_non_zero,
    input  logic                        read,
    input  logic                        write,
    input  rv32_mem_pkg::mem_width_t    width,
    input  logic                        zero_extend,
    input  rv32_branch_pkg::branch_op_t branch_op,
    input  logic [4:0]                  rd,
    input  logic                        rd_write,
    input  logic [31:0]                 result,
    input  logic [31:0]                 rs2_value,
    input  logic [31:0]                 branch_pc,

    // Register file read port
    input  logic [4:0]                  rs_addr,

    output logic                        branch_mispredicted,
    output logic [31:0]                 branch_pc_out,

    // Writeback
    output logic                        wb_valid,
    output logic [4:0]                  wb_rd,
    output logic                        wb_rd_write,
    output logic [31:0]                 wb_rd_value,

    output logic [31:0]                 rs_value
);
    import rv32_mem_pkg::*;

    logic            data_write;
    logic [3:0]      data_write_mask;
    logic [XLEN-1:0] data_address;
    logic [XLEN-1:0] data_write_value;
    logic [XLEN-1:0] data_read_value;

    rv32_mem mem0 (
        .clk                    (clk),
        .reset_                 (reset_),
        .stall                  (stall),
        .flush                  (flush),
        .branch_predicted_taken (branch_predicted_taken),
        .valid                  (valid),
        .alu_non_zero           (alu_non_zero),
        .read                   (read),
        .write                  (write),
        .width                  (width),
        .zero_extend            (zero_extend),
        .branch_op              (branch_op),
        .rd                     (rd),
        .rd_write               (rd_write),
        .result                 (result),
        .rs2_value              (rs2_value),
        .branch_pc              (branch_pc),
        .data_read_value        (data_read_value),
        .valid_out              (wb_valid),
        .branch_mispredicted    (branch_mispredicted),
        .rd_out                 (wb_rd),
        .rd_write_out           (wb_rd_write),
        // Reads have no side effect in the RAM
        .data_read              (),
        .data_write             (data_write),
        .data_write_mask        (data_write_mask),
        .rd_value_out           (wb_rd_value),
        .branch_pc_out          (branch_pc_out),
        .data_address           (data_address),
        .data_write_value       (data_write_value)
    );

    rv32_data_ram ram0 (
        .clk         (clk),
        .write       (data_write),
        .write_mask  (data_write_mask),
        .address     (data_address),
        .write_value (data_write_value),
        .read_value  (data_read_value)
    );

    rv32_regfile regfile0 (
        .clk         (clk),
        .write       (wb_rd_write),
        .write_addr  (wb_rd),
        .write_value (wb_rd_value),
        .read_addr   (rs_addr),
        .read_value  (rs_value)
    );

endmodule

// File: testbench/rv32_mem_tb.sv
module rv32_mem_tb;
    import rv32_mem_pkg::*;
    import rv32_branch_pkg::*;

    localparam int DRIVE_DELAY   = 10;
    localparam int CHECK_DELAY   = 70;
    localparam int RESET_CYCLES  = 8;
    localparam int RESET_TIMEOUT = 20;
    localparam int RAM_BYTES     = 4 << RAM_ADDR_BITS;

    // One cycle of stimulus and its expected values
    typedef struct packed {
        logic [3:0]  group;
        logic        stall;
        logic        flush;
        logic        valid;
        logic        pred;
        logic        alu_nz;
        logic        read;
        logic        write;
        mem_width_t  width;
        logic        zext;
        branch_op_t  bop;
        logic [4:0]  rd;
        logic        rd_write;
        logic [31:0] result;
        logic [31:0] rs2;
        logic [31:0] bpc;
        logic [4:0]  rs_addr;
        logic        exp_mispred;
        logic        exp_wb_valid;
        logic [4:0]  exp_wb_rd;
        logic        exp_wb_rd_write;
        logic [31:0] exp_wb_value;
        logic [31:0] exp_rs_value;
    } row_t;

    logic        clk;
    logic        reset_;
    logic        stall;
    logic        flush;
    logic        valid;
    logic        branch_predicted_taken;
    logic        alu_non_zero;
    logic        read;
    logic        write;
    mem_width_t  width;
    logic        zero_extend;
    branch_op_t  branch_op;
    logic [4:0]  rd;
    logic        rd_write;
    logic [31:0] result;
    logic [31:0] rs2_value;
    logic [31:0] branch_pc;
    logic [4:0]  rs_addr;
    logic        branch_mispredicted;
    logic [31:0] branch_pc_out;
    logic        wb_valid;
    logic [4:0]  wb_rd;
    logic        wb_rd_write;
    logic [31:0] wb_rd_value;
    logic [31:0] rs_value;

    row_t        rows[$];
    string       test_names [6];
    logic [7:0]  ram_model [RAM_BYTES];
    logic [31:0] reg_model [32];
    int          seed;
    int          rd_counter;
    int          current_row;
    int          test_errors;
    int          tests_passed;
    int          tests_failed;
    int          waited;

    rv32_mem_top dut0 (.*);

    always #50 clk = ~clk;

    initial begin
        reset_ = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        #DRIVE_DELAY;
        reset_ = 1'b1;
    end

    // ####################################################################
    // Row builders

    function automatic row_t idle_row(logic [3:0] group);
        row_t r;
        r = '0;
        r.group = group;
        return r;
    endfunction

    function automatic row_t reg_write_row(logic [3:0] group, logic [4:0] dest,
                                           logic [31:0] value);
        row_t r;
        r = idle_row(group);
        r.valid = 1'b1;
        r.rd = dest;
        r.rd_write = 1'b1;
        r.result = value;
        return r;
    endfunction

    function automatic row_t store_row(logic [3:0] group, logic [31:0] addr, mem_width_t w,
                                       logic [31:0] data);
        row_t r;
        r = idle_row(group);
        r.valid = 1'b1;
        r.write = 1'b1;
        r.width = w;
        r.result = addr;
        r.rs2 = data;
        return r;
    endfunction

    function automatic row_t load_row(logic [3:0] group, logic [31:0] addr, mem_width_t w,
                                      logic zext, logic [4:0] dest);
        row_t r;
        r = reg_write_row(group, dest, addr);
        r.read = 1'b1;
        r.width = w;
        r.zext = zext;
        return r;
    endfunction

    function automatic logic [4:0] next_rd();
        rd_counter = (rd_counter % 31) + 1;
        return 5'(rd_counter);
    endfunction

    // Read port follows the destination of the row two cycles back
    // unless the row names its own register
    task automatic push_row(row_t r);
        if (rows.size() >= 2 && r.rs_addr == 5'd0) begin
            r.rs_addr = rows[rows.size() - 2].rd;
        end
        rows.push_back(r);
    endtask

    task automatic build_table();
        row_t       r;
        mem_width_t w;
        int         off;
        logic [31:0] addr;
        for (int n = 1; n < 32; n++) begin
            push_row(reg_write_row(4'd1, 5'(n), $random(seed)));
        end
        push_row(reg_write_row(4'd1, 5'd0, $random(seed)));
        for (int k = 0; k < 7; k++) begin
            addr = 32'h100 + 32'(4 * k);
            if (k == 0) begin
                w = WIDTH_WORD;
                off = 0;
            end else if (k < 3) begin
                w = WIDTH_HALF;
                off = 2 * (k - 1);
            end else begin
                w = WIDTH_BYTE;
                off = k - 3;
            end
            push_row(store_row(4'd2, addr, WIDTH_WORD, $random(seed)));
            push_row(store_row(4'd2, addr + 32'(off), w, $random(seed)));
            push_row(load_row(4'd2, addr, WIDTH_WORD, 1'b0, next_rd()));
        end
        // Two words with every sign bit pattern on the byte and half lanes
        push_row(store_row(4'd3, 32'h200, WIDTH_WORD,
                           ($random(seed) | 32'h80008000) & 32'hff7fff7f));
        push_row(store_row(4'd3, 32'h204, WIDTH_WORD,
                           ($random(seed) & 32'h7fff7fff) | 32'h00800080));
        for (int wd = 0; wd < 2; wd++) begin
            for (int zx = 0; zx < 2; zx++) begin
                for (int b = 0; b < 4; b++) begin
                    addr = 32'h200 + 32'(4 * wd + b);
                    push_row(load_row(4'd3, addr, WIDTH_BYTE, zx[0], next_rd()));
                end
                for (int h = 0; h < 2; h++) begin
                    addr = 32'h200 + 32'(4 * wd + 2 * h);
                    push_row(load_row(4'd3, addr, WIDTH_HALF, zx[0], next_rd()));
                end
            end
        end
        for (int op = 0; op < 4; op++) begin
            for (int nz = 0; nz < 2; nz++) begin
                for (int p = 0; p < 2; p++) begin
                    r = idle_row(4'd4);
                    r.valid = 1'b1;
                    r.bop = branch_op_t'(op[1:0]);
                    r.alu_nz = nz[0];
                    r.pred = p[0];
                    r.bpc = $random(seed);
                    r.result = $random(seed);
                    push_row(r);
                end
            end
        end
        push_row(reg_write_row(4'd5, 5'd5, $random(seed)));
        r = reg_write_row(4'd5, 5'd6, $random(seed));
        r.stall = 1'b1;
        push_row(r);
        r = reg_write_row(4'd5, 5'd8, $random(seed));
        r.stall = 1'b1;
        push_row(r);
        push_row(reg_write_row(4'd5, 5'd9, $random(seed)));
        r = reg_write_row(4'd5, 5'd7, $random(seed));
        r.flush = 1'b1;
        push_row(r);
        push_row(idle_row(4'd5));
        push_row(idle_row(4'd5));
        // Flushed x7 keeps its earlier value
        r = idle_row(4'd5);
        r.rs_addr = 5'd7;
        push_row(r);
    endtask

    // ####################################################################
    // Reference model

    function automatic int byte_index(logic [31:0] addr);
        return int'({addr[RAM_ADDR_BITS+1:2], 2'b00});
    endfunction

    function automatic logic [31:0] load_model(logic [31:0] addr, mem_width_t w, logic zext);
        int          base;
        int          lane;
        logic [15:0] half;
        logic [7:0]  byte_val;
        base = byte_index(addr);
        case (w)
            WIDTH_HALF: begin
                lane = base + 2 * int'(addr[1]);
                half = {ram_model[lane + 1], ram_model[lane]};
                return zext ? {16'h0, half} : {{16{half[15]}}, half};
            end
            WIDTH_BYTE: begin
                byte_val = ram_model[base + int'(addr[1:0])];
                return zext ? {24'h0, byte_val} : {{24{byte_val[7]}}, byte_val};
            end
            default: begin
                return {ram_model[base + 3], ram_model[base + 2],
                        ram_model[base + 1], ram_model[base]};
            end
        endcase
    endfunction

    task automatic store_model(logic [31:0] addr, mem_width_t w, logic [31:0] data);
        int base;
        base = byte_index(addr);
        case (w)
            WIDTH_WORD: begin
                for (int b = 0; b < 4; b++) begin
                    ram_model[base + b] = data[b*8 +: 8];
                end
            end
            WIDTH_HALF: begin
                ram_model[base + 2 * int'(addr[1])] = data[7:0];
                ram_model[base + 2 * int'(addr[1]) + 1] = data[15:8];
            end
            WIDTH_BYTE: ram_model[base + int'(addr[1:0])] = data[7:0];
            default: ;
        endcase
    endtask

    function automatic logic branch_taken(branch_op_t op, logic nz);
        case (op)
            BRANCH_ZERO:     return !nz;
            BRANCH_NON_ZERO: return nz;
            BRANCH_ALWAYS:   return 1'b1;
            default:         return 1'b0;
        endcase
    endfunction

    // Walks the table cycle by cycle from the reset state
    task automatic fill_expected();
        row_t        r;
        logic        m_valid;
        logic [4:0]  m_rd;
        logic        m_rd_write;
        logic [31:0] m_value;
        logic [31:0] lv;
        m_valid = 1'b0;
        m_rd = '0;
        m_rd_write = 1'b0;
        m_value = '0;
        for (int i = 0; i < rows.size(); i++) begin
            r = rows[i];
            r.exp_wb_valid = m_valid;
            r.exp_wb_rd = m_rd;
            r.exp_wb_rd_write = m_rd_write;
            r.exp_wb_value = m_value;
            r.exp_rs_value = (r.rs_addr == 5'd0) ? 32'h0 : reg_model[r.rs_addr];
            r.exp_mispred = branch_taken(r.bop, r.alu_nz) ^ r.pred;
            lv = load_model(r.result, r.width, r.zext);
            if (m_rd_write && m_rd != 5'd0) begin
                reg_model[m_rd] = m_value;
            end
            if (r.write) begin
                store_model(r.result, r.width, r.rs2);
            end
            if (!r.stall) begin
                m_valid = r.valid & ~r.flush;
                m_rd_write = r.rd_write & ~r.flush;
                m_rd = r.rd;
                m_value = r.read ? lv : r.result;
            end
            rows[i] = r;
        end
    endtask

    // ####################################################################
    // Drive and check

    task automatic apply_row(row_t r);
        stall = r.stall;
        flush = r.flush;
        valid = r.valid;
        branch_predicted_taken = r.pred;
        alu_non_zero = r.alu_nz;
        read = r.read;
        write = r.write;
        width = r.width;
        zero_extend = r.zext;
        branch_op = r.bop;
        rd = r.rd;
        rd_write = r.rd_write;
        result = r.result;
        rs2_value = r.rs2;
        branch_pc = r.bpc;
        rs_addr = r.rs_addr;
    endtask

    task automatic report_mismatch(string name, logic [31:0] got, logic [31:0] exp);
        $display("mismatch at time %0t: row %0d %s is %h, expected %h",
                 $time, current_row, name, got, exp);
        test_errors++;
    endtask

    task automatic check_reset_state();
        if (wb_valid !== 1'b0) report_mismatch("wb_valid", 32'(wb_valid), 32'h0);
        if (wb_rd_write !== 1'b0) report_mismatch("wb_rd_write", 32'(wb_rd_write), 32'h0);
        if (wb_rd !== 5'd0) report_mismatch("wb_rd", 32'(wb_rd), 32'h0);
        if (wb_rd_value !== 32'h0) report_mismatch("wb_rd_value", wb_rd_value, 32'h0);
    endtask

    task automatic compare_outputs(row_t r);
        if (branch_mispredicted !== r.exp_mispred)
            report_mismatch("branch_mispredicted", 32'(branch_mispredicted), 32'(r.exp_mispred));
        if (branch_pc_out !== r.bpc) report_mismatch("branch_pc_out", branch_pc_out, r.bpc);
        if (wb_valid !== r.exp_wb_valid)
            report_mismatch("wb_valid", 32'(wb_valid), 32'(r.exp_wb_valid));
        if (wb_rd !== r.exp_wb_rd) report_mismatch("wb_rd", 32'(wb_rd), 32'(r.exp_wb_rd));
        if (wb_rd_write !== r.exp_wb_rd_write)
            report_mismatch("wb_rd_write", 32'(wb_rd_write), 32'(r.exp_wb_rd_write));
        if (wb_rd_value !== r.exp_wb_value)
            report_mismatch("wb_rd_value", wb_rd_value, r.exp_wb_value);
        if (rs_value !== r.exp_rs_value) report_mismatch("rs_value", rs_value, r.exp_rs_value);
    endtask

    task automatic finish_test(string name);
        if (test_errors == 0) begin
            tests_passed++;
            $display("test %s: ok", name);
        end else begin
            tests_failed++;
            $display("test %s: FAILED with %0d errors", name, test_errors);
        end
        test_errors = 0;
    endtask

    initial begin
        clk = 1'b0;
        seed = 32'h3ab8;
        rd_counter = 0;
        current_row = -1;
        test_errors = 0;
        tests_passed = 0;
        tests_failed = 0;
        test_names = '{"reset", "register writes", "stores", "loads", "branches",
                       "stall and flush"};
        apply_row(idle_row(4'd0));
        build_table();
        fill_expected();

        waited = 0;
        while (reset_ !== 1'b1 && waited < RESET_TIMEOUT) begin
            @(posedge clk);
            #(DRIVE_DELAY + 1);
            waited++;
            check_reset_state();
        end
        if (reset_ !== 1'b1) begin
            $display("error: reset never released after %0d cycles", waited);
            test_errors++;
        end
        finish_test(test_names[0]);

        for (int i = 0; i < rows.size(); i++) begin
            @(posedge clk);
            #DRIVE_DELAY;
            current_row = i;
            apply_row(rows[i]);
            #CHECK_DELAY;
            compare_outputs(rows[i]);
            if (i == rows.size() - 1 || rows[i + 1].group != rows[i].group) begin
                finish_test(test_names[rows[i].group]);
            end
        end

        $display("%0d tests ok, %0d tests failed", tests_passed, tests_failed);
        if (tests_failed == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

// File: filelist.f
hdl/rv32_branch_pkg.sv
hdl/rv32_mem_pkg.sv
hdl/rv32_branch_unit.sv
hdl/rv32_mem.sv
hdl/rv32_data_ram.sv
hdl/rv32_regfile.sv
hdl/rv32_mem_top.sv
testbench/rv32_mem_tb.sv

// File: run.sh
#!/bin/sh
# Compile and run the memory stage testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f filelist.f --top-module rv32_mem_tb \
    -Mdir obj_dir -o rv32_mem_sim \
    && ./obj_dir/rv32_mem_sim > sim.log 2>&1 \
    || { cat sim.log 2>/dev/null; echo "build or simulation error"; exit 1; }

cat sim.log

# The log decides the result
grep -q "Test failures found" sim.log && exit 1 || exit 0
